// ==== list.f ====
+incdir+verification
common/noc_pkg.sv
common/mesh_pkg.sv
common/flit_if.sv
rtl/route_compute.sv
rtl/lookup_slice.sv
rtl/router_lookup.sv
verification/router_lookup_tb.sv

// ==== Makefile ====
TOP = router_lookup_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps -f list.f --top-module $(TOP) -o $(TOP)_sim
	@out="$$(./obj_dir/$(TOP)_sim)"; echo "$$out"; echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir

// ==== verification/router_lookup_model.svh ====
// Reference model for router_lookup, included inside the testbench module
// Needs errors, checks, cycle_count, check_latency and the DUT outputs declared first
// Assumes well formed packets, the same as the DUT
`ifndef router_lookup_model_svh
`define router_lookup_model_svh

// One expected output transfer
typedef struct packed {
  logic [flit_width-1:0] flit;
  logic                  last;
  logic [num_ports-1:0]  valid;
  logic [31:0]           cycle;
} expect_t;

expect_t expect_q[$];

// Packet tracking, a header is expected first
logic    model_in_head = 1'b1;
port_e   model_port    = port_local;

// XY rule, X settled before Y
function automatic port_e xy_port(input logic [flit_width-1:0] hdr);
  int dx;
  int dy;
  dx = int'(hdr[31:30]) - tb_router_x;
  dy = int'(hdr[29:28]) - tb_router_y;
  if (dx != 0) return (dx > 0) ? port_east : port_west;
  if (dy != 0) return (dy > 0) ? port_north : port_south;
  return port_local;
endfunction

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
  checks++;
  if (expected !== actual) begin
    errors++;
    $display("MISMATCH time=%0t signal=%s expected=%0h actual=%0h",
             $time, name, expected, actual);
  end
endtask

// Accepted input flit, body flits reuse the header port
task automatic model_accept(input logic [flit_width-1:0] f, input logic l);
  expect_t e;
  if (model_in_head) begin
    model_port = xy_port(f);
  end
  model_in_head    = l;
  e.flit           = f;
  e.last           = l;
  e.valid          = '0;
  e.valid[model_port] = 1'b1;
  e.cycle          = cycle_count;
  expect_q.push_back(e);
endtask

// Output transfer, oldest expected flit must match
task automatic model_output();
  expect_t e;
  if (expect_q.size() == 0) begin
    errors++;
    $display("ERROR at %0t: output transfer while no flit was expected", $time);
  end else begin
    e = expect_q.pop_front();
    check_value("out_flit", e.flit, out_flit);
    check_value("out_last", 32'(e.last), 32'(out_last));
    check_value("out_valid", 32'(e.valid), 32'(out_valid));
    // Free output means one cycle from accept to out_valid
    if (check_latency) check_value("latency", 32'd1, cycle_count - e.cycle);
  end
endtask

`endif

// ==== verification/router_lookup_tb.sv ====
// Testbench for router_lookup placed at mesh position (1,2)
// Random packets under random per-port back-pressure, checked against a model
// Each handshake wait gives up after wait_limit cycles
`timescale 1ns/1ps

module router_lookup_tb
  import noc_pkg::*, mesh_pkg::*;
();

  localparam int          tb_router_x = 1;
  localparam int          tb_router_y = 2;
  localparam int          clk_period  = 8;
  localparam logic [31:0] seed_init   = 32'h3e6b0d6c;
  localparam int          num_packets = 150;
  localparam int          wait_limit  = 200;
  // out_ready modes
  localparam int          mode_random = 0;
  localparam int          mode_high   = 1;
  localparam int          mode_stall  = 2;
  // Only the east port stalls in mode_stall
  localparam logic [num_ports-1:0] stall_mask = num_ports'(1 << port_east);

  logic                  clk       = 1'b0;
  logic                  rst       = 1'b1;
  logic [flit_width-1:0] in_flit   = '0;
  logic                  in_last   = 1'b0;
  logic                  in_valid  = 1'b0;
  logic                  in_ready;
  logic [flit_width-1:0] out_flit;
  logic                  out_last;
  logic [num_ports-1:0]  out_valid;
  logic [num_ports-1:0]  out_ready = '0;

  int          errors        = 0;
  int          checks        = 0;
  int          accept_count  = 0;
  int          ready_mode    = mode_random;
  logic        check_latency = 1'b0;
  logic [31:0] cycle_count   = '0;
  integer      stim_seed     = seed_init;
  integer      ready_seed    = seed_init ^ 32'h0000ffff;

  `include "router_lookup_model.svh"

  router_lookup #(
    .router_x (coord_width'(tb_router_x)),
    .router_y (coord_width'(tb_router_y))
  ) u_router_lookup (
    .clk       (clk),
    .rst       (rst),
    .in_flit   (in_flit),
    .in_last   (in_last),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_flit  (out_flit),
    .out_last  (out_last),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  always #(clk_period / 2) clk = ~clk;

  always @(posedge clk) cycle_count <= cycle_count + 32'd1;

  // Back-pressure where random mode mixes full stalls and full bursts
  always @(posedge clk) begin
    case (ready_mode)
      mode_high:  out_ready <= '1;
      mode_stall: out_ready <= ~stall_mask;
      default: begin
        case ({$random(ready_seed)} % 8)
          0:       out_ready <= '0;
          1:       out_ready <= '1;
          default: out_ready <= num_ports'($random(ready_seed));
        endcase
      end
    endcase
  end

  // Mid-cycle monitor of output transfers and input accepts
  always @(negedge clk) begin
    if (!rst) begin
      check_value("out_valid_onehot", 32'd1, 32'($onehot0(out_valid)));
      if (|(out_valid & out_ready)) model_output();
      if (in_valid && in_ready) begin
        accept_count++;
        model_accept(in_flit, in_last);
      end
    end
  end

  task automatic end_run();
    $display("checks=%0d errors=%0d", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  endtask

  task automatic abort_run(input string what);
    errors++;
    $display("TIMEOUT at %0t: %s", $time, what);
    end_run();
  endtask

  // Starts and ends on a rising edge and drops in_valid after the accepting edge
  task automatic send_flit(input logic [flit_width-1:0] f, input logic l, input int gap);
    int waited;
    waited = 0;
    repeat (gap) begin
      in_valid <= 1'b0;
      @(posedge clk);
    end
    in_flit  <= f;
    in_last  <= l;
    in_valid <= 1'b1;
    @(negedge clk);
    while (!in_ready) begin
      if (waited == wait_limit) abort_run("input flit was never accepted");
      waited++;
      @(negedge clk);
    end
    @(posedge clk);
    in_valid <= 1'b0;
  endtask

  task automatic send_packet(input logic [coord_width-1:0] dx,
                             input logic [coord_width-1:0] dy, input int len, input int max_gap);
    logic [flit_width-1:0] f;
    int                    gap;
    for (int i = 0; i < len; i++) begin
      f = $random(stim_seed);
      // Header carries the destination
      if (i == 0) f[31:28] = {dx, dy};
      gap = int'({$random(stim_seed)} % (max_gap + 1));
      send_flit(f, i == len - 1, gap);
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (expect_q.size() != 0) begin
      if (waited == wait_limit) abort_run("expected flits never left the DUT");
      waited++;
      @(posedge clk);
    end
  endtask

  // East held not ready so the slice takes two flits and closes the input
  task automatic stall_test();
    logic [flit_width-1:0] flits [4];
    int                    sent;
    int                    start_count;
    for (int i = 0; i < 4; i++) flits[i] = $random(stim_seed);
    // Destination (3,0) leaves east from (1,2)
    flits[0][31:28] = {2'd3, 2'd0};
    ready_mode <= mode_stall;
    @(posedge clk);
    start_count = accept_count;
    sent        = 0;
    in_flit  <= flits[0];
    in_last  <= 1'b0;
    in_valid <= 1'b1;
    repeat (12) begin
      @(negedge clk);
      if (in_ready && sent < 3) sent++;
      @(posedge clk);
      in_flit <= flits[sent];
      in_last <= (sent == 3);
    end
    @(negedge clk);
    check_value("in_ready", 32'd0, 32'(in_ready));
    @(posedge clk);
    check_value("stall_accepted", 32'd2, 32'(accept_count - start_count));
    // East ready returns and the rest of the packet follows
    ready_mode <= mode_random;
    for (int i = sent; i < 4; i++) send_flit(flits[i], i == 3, 0);
  endtask

  initial begin
    logic [coord_width-1:0] dx;
    logic [coord_width-1:0] dy;
    int                     len;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_value("out_valid", 32'd0, 32'(out_valid));
    check_value("in_ready", 32'd1, 32'(in_ready));
    @(posedge clk);
    // One packet per port with local last
    send_packet(2'd3, 2'd2, 1, 0);
    send_packet(2'd0, 2'd2, 2, 0);
    send_packet(2'd1, 2'd3, 1, 1);
    send_packet(2'd1, 2'd0, 3, 1);
    send_packet(2'd1, 2'd2, 2, 0);
    for (int i = 0; i < num_packets; i++) begin
      dx  = coord_width'($random(stim_seed));
      dy  = coord_width'($random(stim_seed));
      len = 1 + int'({$random(stim_seed)} % 4);
      send_packet(dx, dy, len, 3);
    end
    // Full-ready phase with latency checks
    wait_drain();
    ready_mode    <= mode_high;
    check_latency <= 1'b1;
    @(posedge clk);
    for (int i = 0; i < 30; i++) begin
      dx  = coord_width'($random(stim_seed));
      dy  = coord_width'($random(stim_seed));
      len = 1 + int'({$random(stim_seed)} % 4);
      send_packet(dx, dy, len, 2);
    end
    wait_drain();
    check_latency <= 1'b0;
    stall_test();
    wait_drain();
    // Idle window where a stray extra output transfer gets flagged
    ready_mode <= mode_high;
    repeat (4) @(posedge clk);
    end_run();
  end

endmodule

// ==== rtl/router_lookup.sv ====
// Input-side lookup stage of one mesh router
// router_x and router_y give this router's own mesh position
// One cycle from accepted input flit to out_valid when the output is free
// No crossbar, arbitration or credit flow here
`timescale 1ns/1ps

module router_lookup
  import noc_pkg::*, mesh_pkg::*;
#(
  parameter logic [coord_width-1:0] router_x = '0,
  parameter logic [coord_width-1:0] router_y = '0
) (
  input  logic                  clk,
  input  logic                  rst,

  // Input link
  input  logic [flit_width-1:0] in_flit,
  input  logic                  in_last,
  input  logic                  in_valid,
  output logic                  in_ready,

  // Output link
  // One-hot valid with one ready per port
  output logic [flit_width-1:0] out_flit,
  output logic                  out_last,
  output logic [num_ports-1:0]  out_valid,
  input  logic [num_ports-1:0]  out_ready
);

  ////////////////////////////////////////////////////////////////////////////
  // Route to slice link
  ////////////////////////////////////////////////////////////////////////////

  flit_if route_link ();

  // XY route and per-packet port hold
  route_compute #(
    .router_x (router_x),
    .router_y (router_y)
  ) u_route (
    .clk      (clk),
    .rst      (rst),
    .in_flit  (in_flit),
    .in_last  (in_last),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .down     (route_link.src)
  );

  // Registered outputs with skid entry
  lookup_slice u_slice (
    .clk       (clk),
    .rst       (rst),
    .up        (route_link.dst),
    .out_flit  (out_flit),
    .out_last  (out_last),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

endmodule

// ==== rtl/lookup_slice.sv ====
// Two-entry skid buffer that drives the router output registers
// Input ready depends only on a register, so no combinational path from out_ready
// A stalled port blocks this input path until its own ready returns
`timescale 1ns/1ps

module lookup_slice
  import noc_pkg::*, mesh_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  flit_if.dst                   up,
  output logic [flit_width-1:0] out_flit,
  output logic                  out_last,
  output logic [num_ports-1:0]  out_valid,
  input  logic [num_ports-1:0]  out_ready
);

  ////////////////////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////////////////////

  // Second entry, filled only while the output entry is stalled
  logic [flit_width-1:0] skid_flit;
  logic                  skid_last;
  logic [num_ports-1:0]  skid_valid;

  // Skid entry full, input blocked
  // Also steers the next flit into the output entry
  logic                  pressure;

  logic                  out_full;
  logic                  out_xfer;
  logic                  in_offer;

  // Output entry holds a flit
  assign out_full = |out_valid;

  // Held flit leaves only on its own port
  assign out_xfer = |(out_valid & out_ready);

  // Route stage offers a flit
  assign in_offer = |up.valid;

  // Back-pressure reaches the input one cycle after the stall
  assign up.ready = ~pressure;

  ////////////////////////////////////////////////////////////////////////////
  // Entry update
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      pressure  <= 1'b0;
      out_valid <= '0;
    end else if (!pressure) begin
      if (!out_full || out_xfer) begin
        // Output entry free this cycle
        // An empty offer leaves it empty
        out_flit  <= up.flit;
        out_last  <= up.last;
        out_valid <= up.valid;
      end else if (in_offer) begin
        // Output stalled, park the new flit
        skid_flit  <= up.flit;
        skid_last  <= up.last;
        skid_valid <= up.valid;
        pressure   <= 1'b1;
      end
    end else begin
      // Output entry is always full here
      if (out_xfer) begin
        // Skid flit moves up, input reopens
        out_flit  <= skid_flit;
        out_last  <= skid_last;
        out_valid <= skid_valid;
        pressure  <= 1'b0;
      end
    end
  end

  // Ordering holds since the skid entry is drained
  // before any new input is taken

endmodule

// ==== rtl/route_compute.sv ====
// XY route stage for one router input
// X is resolved first and then Y, which keeps the mesh free of deadlock
// Assumes well formed packets where a header always follows a last flit
// Purely combinational from input to down, in_ready mirrors down.ready
`timescale 1ns/1ps

module route_compute
  import noc_pkg::*, mesh_pkg::*;
#(
  parameter logic [coord_width-1:0] router_x = '0,
  parameter logic [coord_width-1:0] router_y = '0
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [flit_width-1:0] in_flit,
  input  logic                  in_last,
  input  logic                  in_valid,
  output logic                  in_ready,
  flit_if.src                   down
);

  // Header expected or inside a packet
  typedef enum logic {
    state_head,
    state_body
  } route_state_e;

  route_state_e           state;
  // Port latched from the header for the body flits
  port_e                  port_q;
  port_e                  hdr_port;
  port_e                  sel_port;
  logic [coord_width-1:0] dest_x;
  logic [coord_width-1:0] dest_y;
  logic [num_ports-1:0]   port_vec;
  logic                   accept;

  ////////////////////////////////////////////////////////////////////////////
  // Route decision
  ////////////////////////////////////////////////////////////////////////////

  // Destination fields, only meaningful on a header
  assign dest_x = in_flit[dest_x_lsb +: coord_width];
  assign dest_y = in_flit[dest_y_lsb +: coord_width];

  // Dimension order, X first
  always_comb begin
    if (dest_x > router_x) begin
      hdr_port = port_east;
    end else if (dest_x < router_x) begin
      hdr_port = port_west;
    end else if (dest_y > router_y) begin
      hdr_port = port_north;
    end else if (dest_y < router_y) begin
      hdr_port = port_south;
    end else begin
      // Both coordinates match, eject here
      hdr_port = port_local;
    end
  end

  // Header routes afresh, body reuses the latched port
  assign sel_port = (state == state_head) ? hdr_port : port_q;

  // Port index to one-hot
  always_comb begin
    port_vec           = '0;
    port_vec[sel_port] = 1'b1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Link drive
  ////////////////////////////////////////////////////////////////////////////

  assign down.flit  = in_flit;
  assign down.last  = in_last;
  // Nothing offered without an input flit
  assign down.valid = in_valid ? port_vec : '0;
  assign in_ready   = down.ready;
  assign accept     = in_valid & down.ready;

  // Packet tracking, advances only on an accepted flit
  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= state_head;
      port_q <= port_local;
    end else if (accept) begin
      if (state == state_head) begin
        port_q <= hdr_port;
        // Single flit packets stay in head
        if (!in_last) begin
          state <= state_body;
        end
      end else if (in_last) begin
        state <= state_head;
      end
    end
  end

endmodule

// ==== common/flit_if.sv ====
// Flit link from the route stage into the lookup slice
// A flit moves when any valid bit and ready are high in the same cycle
// The source holds flit, last and valid stable until then
`timescale 1ns/1ps

interface flit_if
  import noc_pkg::*, mesh_pkg::*;
();

  // Flit payload, header or body
  logic [flit_width-1:0] flit;

  // Marks the final flit of a packet
  logic                  last;

  // One-hot selected output port
  // All zeros means nothing offered
  logic [num_ports-1:0]  valid;

  // Sink can take a flit this cycle
  logic                  ready;

  // Route stage side
  modport src (output flit, output last, output valid, input ready);

  // Lookup slice side
  modport dst (input flit, input last, input valid, output ready);

endinterface

// ==== common/mesh_pkg.sv ====
// Mesh topology seen from one router
// Square mesh with one local port and four neighbor ports
// Port indices double as bit positions in the one-hot port vector

package mesh_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Mesh size
  ////////////////////////////////////////////////////////////////////////////

  // Routers along each side of the mesh
  localparam int unsigned mesh_dim = 4;

  // Local port plus four compass directions
  localparam int unsigned num_ports = 5;

  ////////////////////////////////////////////////////////////////////////////
  // Output ports
  ////////////////////////////////////////////////////////////////////////////

  // Index into the one-hot valid vector
  typedef enum logic [2:0] {
    // Packet has arrived at this router
    port_local = 3'd0,
    // Towards increasing Y
    port_north = 3'd1,
    // Towards increasing X
    port_east  = 3'd2,
    // Towards decreasing Y
    port_south = 3'd3,
    // Towards decreasing X
    port_west  = 3'd4
  } port_e;

endpackage

// ==== common/noc_pkg.sv ====
// Flit format of the router input path
// Only header flits carry destination fields and body flits are opaque
// Coordinates are unsigned mesh indices with the origin at the south-west corner

package noc_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Flit geometry
  ////////////////////////////////////////////////////////////////////////////

  // Width of every flit on the link
  localparam int unsigned flit_width = 32;

  // Width of one mesh coordinate
  localparam int unsigned coord_width = 2;

  ////////////////////////////////////////////////////////////////////////////
  // Header fields
  ////////////////////////////////////////////////////////////////////////////

  // Destination X sits in bits 31..30 of a header
  localparam int unsigned dest_x_lsb = 30;

  // Destination Y sits in bits 29..28 of a header
  localparam int unsigned dest_y_lsb = 28;

  // Bits 27..0 are free for the packet payload

endpackage
